//--- include/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// rob slots, slot 0 is never allocated
`define ROB_SIZE 8

// rob tag width, tag 0 means the value sits in the register file
`define TAG_W 3

// data word width
`define DATA_W 64

// architectural register index width
`define REG_W 5

// reservation stations fed by dispatch
`define NUM_RS 4

`endif

//--- hw/renamePkg.sv
`default_nettype none

`include "rename_defines.svh"

package renamePkg;

  typedef enum logic [1:0] {
    CMD_ALU,
    CMD_LOAD,
    CMD_STORE,
    CMD_BRANCH
  } cmdType_e;

  // also the reservation station index
  typedef enum logic [1:0] {
    FU_ALU,
    FU_MUL,
    FU_MEM,
    FU_BRANCH
  } fuSel_e;

  typedef struct packed {
    logic [`REG_W-1:0]  rd;
    logic [`REG_W-1:0]  rn;
    logic [`REG_W-1:0]  rm;
    logic [8:0]         dAddr9;
    logic [11:0]        imm12;
    logic [`DATA_W-1:0] pc;
    cmdType_e           cmd;
    fuSel_e             fu;
    logic               reg2Loc;
    logic               regWrite;
    logic               aluSrc;
    logic               dOrImm;
    logic               memWrite;
    logic               memToReg;
    logic               leftShift;
    logic               saveCond;
  } instr_t;

  typedef struct packed {
    logic     memWrite;
    logic     memToReg;
    logic     regWrite;
    logic     leftShift;
    logic     saveCond;
    cmdType_e cmd;
  } rsCmd_t;

  typedef struct packed {
    logic [`TAG_W-1:0]  destTag;
    logic [`TAG_W-1:0]  tag1;
    logic [`DATA_W-1:0] val1;
    logic [`TAG_W-1:0]  tag2;
    logic [`DATA_W-1:0] val2;
    rsCmd_t             ctrl;
  } dispatch_t;

  typedef struct packed {
    logic               valid;
    logic [`TAG_W-1:0]  tag;
    logic [`DATA_W-1:0] value;
  } cdb_t;

  typedef struct packed {
    logic               valid;
    logic               regWrite;
    logic [`REG_W-1:0]  rd;
    logic [`TAG_W-1:0]  tag;
    logic [`DATA_W-1:0] value;
  } commit_t;

endpackage

`default_nettype wire

//--- hw/regFile.sv
`default_nettype none

`include "rename_defines.svh"

module regFile import renamePkg::*; (
  input  logic               clk_i,
  input  logic               rstN_i,
  input  logic [`REG_W-1:0]  rdAddr1_i,
  input  logic [`REG_W-1:0]  rdAddr2_i,
  output logic [`DATA_W-1:0] rdData1_o,
  output logic [`DATA_W-1:0] rdData2_o,
  input  commit_t            commit_i
);

  localparam int NumRegs = 1 << `REG_W;
  localparam logic [`REG_W-1:0] ZeroReg = `REG_W'(NumRegs - 1);

  logic [`DATA_W-1:0] regs [NumRegs];

  // retirement is the only writer
  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (commit_i.valid && commit_i.regWrite && commit_i.rd != ZeroReg) begin
      regs[commit_i.rd] <= commit_i.value;
    end
  end

  // x31 is the zero register
  assign rdData1_o = (rdAddr1_i == ZeroReg) ? '0 : regs[rdAddr1_i];
  assign rdData2_o = (rdAddr2_i == ZeroReg) ? '0 : regs[rdAddr2_i];

endmodule

`default_nettype wire

//--- hw/mapTable.sv
`default_nettype none

`include "rename_defines.svh"

module mapTable import renamePkg::*; (
  input  logic              clk_i,
  input  logic              rstN_i,
  input  logic [`REG_W-1:0] rdAddr1_i,
  input  logic [`REG_W-1:0] rdAddr2_i,
  output logic [`TAG_W-1:0] rdTag1_o,
  output logic [`TAG_W-1:0] rdTag2_o,
  input  logic              renameEn_i,
  input  logic [`REG_W-1:0] renameReg_i,
  input  logic [`TAG_W-1:0] renameTag_i,
  input  commit_t           commit_i
);

  localparam int NumRegs = 1 << `REG_W;

  // newest in-flight producer per register, 0 when none
  logic [`TAG_W-1:0] aliasTag [NumRegs];
  logic              clearHit;

  // only clear if nobody renamed the register after the retiring producer
  assign clearHit = commit_i.valid &&
                    (aliasTag[commit_i.rd] == commit_i.tag) &&
                    !(renameEn_i && (renameReg_i == commit_i.rd));

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      for (int i = 0; i < NumRegs; i++) begin
        aliasTag[i] <= '0;
      end
    end else begin
      if (clearHit) begin
        aliasTag[commit_i.rd] <= '0;
      end
      if (renameEn_i) begin
        aliasTag[renameReg_i] <= renameTag_i;
      end
    end
  end

  assign rdTag1_o = aliasTag[rdAddr1_i];
  assign rdTag2_o = aliasTag[rdAddr2_i];

endmodule

`default_nettype wire

//--- hw/reorderBuffer.sv
`default_nettype none

`include "rename_defines.svh"

module reorderBuffer import renamePkg::*; (
  input  logic               clk_i,
  input  logic               rstN_i,
  input  logic               allocEn_i,
  input  logic [`REG_W-1:0]  allocRd_i,
  input  logic               allocRegWrite_i,
  input  cmdType_e           allocCmd_i,
  output logic [`TAG_W-1:0]  tailTag_o,
  output logic               full_o,
  input  cdb_t               cdb_i,
  input  logic [`TAG_W-1:0]  rdTag1_i,
  input  logic [`TAG_W-1:0]  rdTag2_i,
  output logic               rdReady1_o,
  output logic               rdReady2_o,
  output logic [`DATA_W-1:0] rdVal1_o,
  output logic [`DATA_W-1:0] rdVal2_o,
  output commit_t            commit_o
);

  localparam logic [`TAG_W-1:0] FirstTag = `TAG_W'(1);
  localparam logic [`TAG_W-1:0] LastTag  = `TAG_W'(`ROB_SIZE - 1);

  // per-slot control state
  logic               entValid [`ROB_SIZE];
  logic               entReady [`ROB_SIZE];
  // per-slot payload
  logic [`REG_W-1:0]  entRd [`ROB_SIZE];
  logic               entRegWrite [`ROB_SIZE];
  cmdType_e           entCmd [`ROB_SIZE];
  logic [`DATA_W-1:0] entValue [`ROB_SIZE];

  logic [`TAG_W-1:0] headTag;
  logic [`TAG_W-1:0] tailTag;
  logic [`TAG_W-1:0] count;
  logic              retire;

  // slot 0 is skipped when wrapping
  function automatic logic [`TAG_W-1:0] nextTag(input logic [`TAG_W-1:0] tag);
    return (tag == LastTag) ? FirstTag : tag + `TAG_W'(1);
  endfunction

  assign retire = entValid[headTag] && entReady[headTag];
  assign full_o = (count == LastTag);
  assign tailTag_o = tailTag;

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      for (int i = 0; i < `ROB_SIZE; i++) begin
        entValid[i] <= 1'b0;
        entReady[i] <= 1'b0;
      end
      headTag <= FirstTag;
      tailTag <= FirstTag;
      count   <= '0;
    end else begin
      if (cdb_i.valid && entValid[cdb_i.tag]) begin
        entReady[cdb_i.tag] <= 1'b1;
      end
      if (retire) begin
        entValid[headTag] <= 1'b0;
        headTag           <= nextTag(headTag);
      end
      if (allocEn_i) begin
        entValid[tailTag] <= 1'b1;
        entReady[tailTag] <= 1'b0;
        tailTag           <= nextTag(tailTag);
      end
      count <= count + `TAG_W'(allocEn_i) - `TAG_W'(retire);
    end
  end

  always_ff @(posedge clk_i) begin
    if (cdb_i.valid) begin
      entValue[cdb_i.tag] <= cdb_i.value;
    end
    if (allocEn_i) begin
      entRd[tailTag]       <= allocRd_i;
      entRegWrite[tailTag] <= allocRegWrite_i;
      entCmd[tailTag]      <= allocCmd_i;
    end
  end

  // operand lookups, tag 0 is never valid so it reads as not ready
  assign rdReady1_o = entValid[rdTag1_i] && entReady[rdTag1_i];
  assign rdReady2_o = entValid[rdTag2_i] && entReady[rdTag2_i];
  assign rdVal1_o   = entValue[rdTag1_i];
  assign rdVal2_o   = entValue[rdTag2_i];

  // stores carry no register result
  assign commit_o.valid    = retire;
  assign commit_o.regWrite = entRegWrite[headTag] && (entCmd[headTag] != CMD_STORE);
  assign commit_o.rd       = entRd[headTag];
  assign commit_o.tag      = headTag;
  assign commit_o.value    = entValue[headTag];

endmodule

`default_nettype wire

//--- hw/decodeStage.sv
`default_nettype none

`include "rename_defines.svh"

module decodeStage import renamePkg::*; (
  input  logic               instValid_i,
  input  instr_t             inst_i,
  input  logic [`NUM_RS-1:0] rsStall_i,
  output logic [`REG_W-1:0]  mapAddr1_o,
  output logic [`REG_W-1:0]  mapAddr2_o,
  output logic [`REG_W-1:0]  regAddr1_o,
  output logic [`REG_W-1:0]  regAddr2_o,
  input  logic [`TAG_W-1:0]  mapTag1_i,
  input  logic [`TAG_W-1:0]  mapTag2_i,
  input  logic [`DATA_W-1:0] regVal1_i,
  input  logic [`DATA_W-1:0] regVal2_i,
  output logic [`TAG_W-1:0]  robTag1_o,
  output logic [`TAG_W-1:0]  robTag2_o,
  input  logic               robReady1_i,
  input  logic               robReady2_i,
  input  logic [`DATA_W-1:0] robVal1_i,
  input  logic [`DATA_W-1:0] robVal2_i,
  input  logic [`TAG_W-1:0]  tailTag_i,
  input  logic               robFull_i,
  output logic               renameEn_o,
  output logic               allocEn_o,
  output dispatch_t          dispatch_o,
  output logic [`NUM_RS-1:0] rsWriteEn_o,
  output logic               decodeStall_o
);

  logic [`REG_W-1:0]  src2Reg;
  logic               accept;
  logic [`DATA_W-1:0] dAddrExt;
  logic [`DATA_W-1:0] immExt;

  // reg2Loc picks rd as the second source, as stores and cbz need
  assign src2Reg = inst_i.reg2Loc ? inst_i.rd : inst_i.rm;

  assign mapAddr1_o = inst_i.rn;
  assign mapAddr2_o = src2Reg;
  assign regAddr1_o = inst_i.rn;
  assign regAddr2_o = src2Reg;
  assign robTag1_o  = mapTag1_i;
  assign robTag2_o  = mapTag2_i;

  assign decodeStall_o = robFull_i | (|rsStall_i);
  assign accept        = instValid_i & ~decodeStall_o;
  assign allocEn_o     = accept;
  assign renameEn_o    = accept & inst_i.regWrite;

  // fu doubles as the station index
  assign rsWriteEn_o = accept ? (`NUM_RS'(1) << inst_i.fu) : '0;

  assign dAddrExt = {{(`DATA_W - 9){inst_i.dAddr9[8]}}, inst_i.dAddr9};
  assign immExt   = {{(`DATA_W - 12){inst_i.imm12[11]}}, inst_i.imm12};

  always_comb begin
    dispatch_o.destTag = tailTag_i;

    // source 1: register file, finished rob entry, or wait on the tag
    if (mapTag1_i == '0) begin
      dispatch_o.tag1 = '0;
      dispatch_o.val1 = regVal1_i;
    end else if (robReady1_i) begin
      dispatch_o.tag1 = '0;
      dispatch_o.val1 = robVal1_i;
    end else begin
      dispatch_o.tag1 = mapTag1_i;
      dispatch_o.val1 = '0;
    end

    // source 2 follows the same rule
    if (mapTag2_i == '0) begin
      dispatch_o.tag2 = '0;
      dispatch_o.val2 = regVal2_i;
    end else if (robReady2_i) begin
      dispatch_o.tag2 = '0;
      dispatch_o.val2 = robVal2_i;
    end else begin
      dispatch_o.tag2 = mapTag2_i;
      dispatch_o.val2 = '0;
    end

    // branches carry the pc, immediates replace the register operand
    if (inst_i.cmd == CMD_BRANCH) begin
      dispatch_o.tag2 = '0;
      dispatch_o.val2 = inst_i.pc;
    end else if (inst_i.aluSrc) begin
      dispatch_o.tag2 = '0;
      dispatch_o.val2 = inst_i.dOrImm ? immExt : dAddrExt;
    end

    dispatch_o.ctrl.memWrite  = inst_i.memWrite;
    dispatch_o.ctrl.memToReg  = inst_i.memToReg;
    dispatch_o.ctrl.regWrite  = inst_i.regWrite;
    dispatch_o.ctrl.leftShift = inst_i.leftShift;
    dispatch_o.ctrl.saveCond  = inst_i.saveCond;
    dispatch_o.ctrl.cmd       = inst_i.cmd;
  end

endmodule

`default_nettype wire

//--- hw/renameTop.sv
`default_nettype none

`include "rename_defines.svh"

module renameTop import renamePkg::*; (
  input  logic               clk_i,
  input  logic               rstN_i,
  input  logic               instValid_i,
  input  instr_t             inst_i,
  input  logic [`NUM_RS-1:0] rsStall_i,
  input  cdb_t               cdb_i,
  output dispatch_t          dispatch_o,
  output logic [`NUM_RS-1:0] rsWriteEn_o,
  output logic               decodeStall_o,
  output commit_t            commit_o
);

  logic [`REG_W-1:0]  mapAddr1;
  logic [`REG_W-1:0]  mapAddr2;
  logic [`REG_W-1:0]  regAddr1;
  logic [`REG_W-1:0]  regAddr2;
  logic [`TAG_W-1:0]  mapTag1;
  logic [`TAG_W-1:0]  mapTag2;
  logic [`DATA_W-1:0] regVal1;
  logic [`DATA_W-1:0] regVal2;
  logic [`TAG_W-1:0]  robTag1;
  logic [`TAG_W-1:0]  robTag2;
  logic               robReady1;
  logic               robReady2;
  logic [`DATA_W-1:0] robVal1;
  logic [`DATA_W-1:0] robVal2;
  logic [`TAG_W-1:0]  tailTag;
  logic               robFull;
  logic               renameEn;
  logic               allocEn;

  decodeStage uDecode (
    .instValid_i  (instValid_i),
    .inst_i       (inst_i),
    .rsStall_i    (rsStall_i),
    .mapAddr1_o   (mapAddr1),
    .mapAddr2_o   (mapAddr2),
    .regAddr1_o   (regAddr1),
    .regAddr2_o   (regAddr2),
    .mapTag1_i    (mapTag1),
    .mapTag2_i    (mapTag2),
    .regVal1_i    (regVal1),
    .regVal2_i    (regVal2),
    .robTag1_o    (robTag1),
    .robTag2_o    (robTag2),
    .robReady1_i  (robReady1),
    .robReady2_i  (robReady2),
    .robVal1_i    (robVal1),
    .robVal2_i    (robVal2),
    .tailTag_i    (tailTag),
    .robFull_i    (robFull),
    .renameEn_o   (renameEn),
    .allocEn_o    (allocEn),
    .dispatch_o   (dispatch_o),
    .rsWriteEn_o  (rsWriteEn_o),
    .decodeStall_o(decodeStall_o)
  );

  // renames always point at the tag being allocated this cycle
  mapTable uMap (
    .clk_i      (clk_i),
    .rstN_i     (rstN_i),
    .rdAddr1_i  (mapAddr1),
    .rdAddr2_i  (mapAddr2),
    .rdTag1_o   (mapTag1),
    .rdTag2_o   (mapTag2),
    .renameEn_i (renameEn),
    .renameReg_i(inst_i.rd),
    .renameTag_i(tailTag),
    .commit_i   (commit_o)
  );

  reorderBuffer uRob (
    .clk_i          (clk_i),
    .rstN_i         (rstN_i),
    .allocEn_i      (allocEn),
    .allocRd_i      (inst_i.rd),
    .allocRegWrite_i(inst_i.regWrite),
    .allocCmd_i     (inst_i.cmd),
    .tailTag_o      (tailTag),
    .full_o         (robFull),
    .cdb_i          (cdb_i),
    .rdTag1_i       (robTag1),
    .rdTag2_i       (robTag2),
    .rdReady1_o     (robReady1),
    .rdReady2_o     (robReady2),
    .rdVal1_o       (robVal1),
    .rdVal2_o       (robVal2),
    .commit_o       (commit_o)
  );

  regFile uRegs (
    .clk_i    (clk_i),
    .rstN_i   (rstN_i),
    .rdAddr1_i(regAddr1),
    .rdAddr2_i(regAddr2),
    .rdData1_o(regVal1),
    .rdData2_o(regVal2),
    .commit_i (commit_o)
  );

endmodule

`default_nettype wire

//--- dv/renameTests.sv
`default_nettype none

`include "rename_defines.svh"

module renameTests import renamePkg::*; (
  input  logic clk_i,
  input  logic rstN_i,
  output logic done_o
);

  dispatch_t          disp;
  instr_t             ins;
  logic [`DATA_W-1:0] valX1;
  logic [`DATA_W-1:0] valX2;

  task automatic resetTest();
    #1;
    renameTb.checkHex("rsWriteEn_o", 64'(renameTb.rsWriteEn), 64'd0);
    renameTb.checkHex("decodeStall_o", 64'(renameTb.decodeStall), 64'd0);
    renameTb.checkHex("commit_o.valid", 64'(renameTb.commit.valid), 64'd0);
    @(posedge clk_i);
    #1;
    renameTb.probe(renameTb.makeInst(5'd4, 5'd5, 5'd6, FU_ALU), disp);
    renameTb.checkOperands(disp, 3'd0, 64'd0, 3'd0, 64'd0);
  endtask

  task automatic renameTest();
    ins = renameTb.makeInst(5'd1, 5'd2, 5'd3, FU_ALU);
    ins.leftShift = 1'b1;
    renameTb.issue(ins, disp);
    renameTb.checkOperands(disp, 3'd0, renameTb.regImage[2], 3'd0, renameTb.regImage[3]);
    // x2 waits on the x1 producer, tag 1
    ins = renameTb.makeInst(5'd2, 5'd1, 5'd4, FU_MUL);
    ins.saveCond = 1'b1;
    renameTb.issue(ins, disp);
    renameTb.checkOperands(disp, 3'd1, 64'd0, 3'd0, renameTb.regImage[4]);
  endtask

  task automatic completionTest();
    valX1 = renameTb.randWord();
    valX2 = renameTb.randWord();
    renameTb.expectCommit(5'd1, 3'd1, valX1, 1'b1);
    renameTb.expectCommit(5'd2, 3'd2, valX2, 1'b1);
    // tag 2 finishes first and has to wait behind the head
    renameTb.complete(3'd2, valX2);
    renameTb.idle(2);
    if (renameTb.retiredCount != 0) begin
      renameTb.reportFailure("tag 2 retired ahead of tag 1");
    end
    renameTb.probe(renameTb.makeInst(5'd9, 5'd2, 5'd31, FU_ALU), disp);
    renameTb.checkOperands(disp, 3'd0, valX2, 3'd0, 64'd0);
    renameTb.complete(3'd1, valX1);
    // forwarded from the rob in the cycle after the cdb strobe
    renameTb.probe(renameTb.makeInst(5'd9, 5'd1, 5'd2, FU_ALU), disp);
    renameTb.checkOperands(disp, 3'd0, valX1, 3'd0, valX2);
    renameTb.waitRetired(2);
    renameTb.probe(renameTb.makeInst(5'd9, 5'd1, 5'd2, FU_ALU), disp);
    renameTb.checkOperands(disp, 3'd0, renameTb.regImage[1], 3'd0, renameTb.regImage[2]);
  endtask

  task automatic operandTest();
    logic [63:0] loadVal;
    logic [63:0] branchVal;
    // load with a negative 9-bit offset
    ins = renameTb.makeInst(5'd3, 5'd1, 5'd7, FU_MEM);
    ins.cmd = CMD_LOAD;
    ins.aluSrc = 1'b1;
    ins.memToReg = 1'b1;
    ins.dAddr9 = 9'h1F0;
    renameTb.issue(ins, disp);
    renameTb.checkOperands(disp, 3'd0, valX1, 3'd0, 64'hFFFF_FFFF_FFFF_FFF0);
    ins = renameTb.makeInst(5'd4, 5'd1, 5'd7, FU_ALU);
    ins.aluSrc = 1'b1;
    ins.dOrImm = 1'b1;
    ins.dAddr9 = 9'h0FF;
    ins.imm12 = 12'h7FF;
    renameTb.probe(ins, disp);
    renameTb.checkOperands(disp, 3'd0, valX1, 3'd0, 64'h7FF);
    ins.imm12 = 12'h800;
    renameTb.probe(ins, disp);
    renameTb.checkOperands(disp, 3'd0, valX1, 3'd0, 64'hFFFF_FFFF_FFFF_F800);
    // cbz style branch, the pc replaces source 2
    ins = renameTb.makeInst(5'd2, 5'd31, 5'd2, FU_BRANCH);
    ins.cmd = CMD_BRANCH;
    ins.regWrite = 1'b0;
    ins.reg2Loc = 1'b1;
    ins.pc = 64'h0000_0000_0040_1A2C;
    renameTb.issue(ins, disp);
    renameTb.checkOperands(disp, 3'd0, 64'd0, 3'd0, 64'h0000_0000_0040_1A2C);
    // store data comes from rd, x5 is still zero
    ins = renameTb.makeInst(5'd2, 5'd1, 5'd5, FU_MEM);
    ins.cmd = CMD_STORE;
    ins.regWrite = 1'b0;
    ins.memWrite = 1'b1;
    ins.reg2Loc = 1'b1;
    renameTb.probe(ins, disp);
    renameTb.checkOperands(disp, 3'd0, valX1, 3'd0, valX2);
    loadVal = renameTb.randWord();
    branchVal = renameTb.randWord();
    renameTb.expectCommit(5'd3, 3'd3, loadVal, 1'b1);
    renameTb.expectCommit(5'd2, 3'd4, branchVal, 1'b0);
    renameTb.complete(3'd4, branchVal);
    renameTb.complete(3'd3, loadVal);
    renameTb.waitRetired(4);
  endtask

  task automatic robFullTest();
    logic [2:0]  tags [7];
    logic [63:0] word;
    int          target;
    target = renameTb.retiredCount + 8;
    for (int i = 0; i < 7; i++) begin
      tags[i] = renameTb.expTail;
      renameTb.issue(renameTb.makeInst(5'(10 + i), 5'd31, 5'd31, FU_ALU), disp);
    end
    // eighth instruction held against a full rob
    ins = renameTb.makeInst(5'd17, 5'd10, 5'd31, FU_ALU);
    renameTb.holdStalled(ins, 2);
    word = renameTb.randWord();
    renameTb.expectCommit(5'd10, tags[0], word, 1'b1);
    renameTb.complete(tags[0], word);
    renameTb.issue(ins, disp);
    renameTb.checkOperands(disp, 3'd0, word, 3'd0, 64'd0);
    for (int i = 1; i < 7; i++) begin
      word = renameTb.randWord();
      renameTb.expectCommit(5'(10 + i), tags[i], word, 1'b1);
      renameTb.complete(tags[i], word);
    end
    word = renameTb.randWord();
    renameTb.expectCommit(5'd17, tags[0], word, 1'b1);
    renameTb.complete(tags[0], word);
    renameTb.waitRetired(target);
  endtask

  task automatic backPressureTest();
    logic [2:0] producerTag;
    producerTag = renameTb.expTail;
    renameTb.issue(renameTb.makeInst(5'd20, 5'd31, 5'd31, FU_ALU), disp);
    // a second writer of x20 is blocked by each station in turn
    ins = renameTb.makeInst(5'd20, 5'd31, 5'd31, FU_MUL);
    for (int b = 0; b < 4; b++) begin
      renameTb.rsStall = 4'(1 << b);
      renameTb.holdStalled(ins, 1);
    end
    renameTb.rsStall = '0;
    renameTb.instValid = 1'b0;
    renameTb.issue(renameTb.makeInst(5'd21, 5'd20, 5'd31, FU_ALU), disp);
    renameTb.checkOperands(disp, producerTag, 64'd0, 3'd0, 64'd0);
  endtask

  initial begin
    int waited;
    done_o = 1'b0;
    waited = 0;
    while (rstN_i !== 1'b1 && waited < 50) begin
      @(posedge clk_i);
      waited++;
    end
    if (rstN_i !== 1'b1) begin
      renameTb.reportFailure("reset was never released");
    end
    @(posedge clk_i);
    #1;
    resetTest();
    renameTest();
    completionTest();
    operandTest();
    robFullTest();
    backPressureTest();
    done_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/renameTb.sv
`default_nettype none

`include "rename_defines.svh"

module renameTb import renamePkg::*; ();

  logic               clk;
  logic               rstN;
  logic               instValid;
  instr_t             inst;
  logic [`NUM_RS-1:0] rsStall;
  cdb_t               cdb;
  dispatch_t          dispatch;
  logic [`NUM_RS-1:0] rsWriteEn;
  logic               decodeStall;
  commit_t            commit;
  logic               testsDone;

  int                 errors;
  int                 seed;
  int                 retiredCount;
  // architectural registers as they should look after each retirement
  logic [`DATA_W-1:0] regImage [32];
  logic [`TAG_W-1:0]  expTail;
  commit_t            expCommits [$];

  renameTop uut (
    .clk_i        (clk),
    .rstN_i       (rstN),
    .instValid_i  (instValid),
    .inst_i       (inst),
    .rsStall_i    (rsStall),
    .cdb_i        (cdb),
    .dispatch_o   (dispatch),
    .rsWriteEn_o  (rsWriteEn),
    .decodeStall_o(decodeStall),
    .commit_o     (commit)
  );

  renameTests tests (
    .clk_i (clk),
    .rstN_i(rstN),
    .done_o(testsDone)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic checkHex(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic reportFailure(input string what);
    errors++;
    $display("%s", what);
  endtask

  function automatic logic [`DATA_W-1:0] randWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  // plain register-to-register op writing rd
  function automatic instr_t makeInst(input logic [4:0] rd, input logic [4:0] rn,
                                      input logic [4:0] rm, input fuSel_e fu);
    instr_t ins;
    ins = '0;
    ins.rd = rd;
    ins.rn = rn;
    ins.rm = rm;
    ins.fu = fu;
    ins.regWrite = 1'b1;
    return ins;
  endfunction

  task automatic checkOperands(input dispatch_t disp, input logic [2:0] tag1,
                               input logic [63:0] val1, input logic [2:0] tag2,
                               input logic [63:0] val2);
    checkHex("dispatch_o.tag1", 64'(disp.tag1), 64'(tag1));
    checkHex("dispatch_o.val1", disp.val1, val1);
    checkHex("dispatch_o.tag2", 64'(disp.tag2), 64'(tag2));
    checkHex("dispatch_o.val2", disp.val2, val2);
  endtask

  // station control bits follow rsCmd_t field order
  task automatic checkCtrl(input instr_t ins, input dispatch_t disp);
    checkHex("dispatch_o.ctrl", 64'(disp.ctrl),
             64'({ins.memWrite, ins.memToReg, ins.regWrite,
                  ins.leftShift, ins.saveCond, ins.cmd}));
  endtask

  // all drive tasks start and end 1 unit after a rising edge
  task automatic issue(input instr_t ins, output dispatch_t disp);
    int waited;
    inst = ins;
    instValid = 1'b1;
    #1;
    waited = 0;
    while (decodeStall && waited < 50) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (decodeStall) begin
      reportFailure($sformatf("instruction for x%0d was never accepted", ins.rd));
    end else begin
      checkHex("dispatch_o.destTag", 64'(dispatch.destTag), 64'(expTail));
      checkHex("rsWriteEn_o", 64'(rsWriteEn), 64'(4'b0001 << ins.fu));
      checkCtrl(ins, dispatch);
      expTail = (expTail == 3'd7) ? 3'd1 : expTail + 3'd1;
    end
    disp = dispatch;
    @(posedge clk);
    #1;
    instValid = 1'b0;
  endtask

  // shows an instruction without instValid, so nothing is allocated
  task automatic probe(input instr_t ins, output dispatch_t disp);
    inst = ins;
    instValid = 1'b0;
    #1;
    disp = dispatch;
    checkHex("rsWriteEn_o", 64'(rsWriteEn), 64'd0);
    checkCtrl(ins, disp);
    @(posedge clk);
    #1;
  endtask

  // leaves instValid high, the caller decides when to drop it
  task automatic holdStalled(input instr_t ins, input int cycles);
    inst = ins;
    instValid = 1'b1;
    repeat (cycles) begin
      #1;
      checkHex("decodeStall_o", 64'(decodeStall), 64'd1);
      checkHex("rsWriteEn_o", 64'(rsWriteEn), 64'd0);
      @(posedge clk);
      #1;
    end
  endtask

  task automatic complete(input logic [2:0] tag, input logic [63:0] value);
    cdb.valid = 1'b1;
    cdb.tag = tag;
    cdb.value = value;
    @(posedge clk);
    #1;
    cdb = '0;
  endtask

  task automatic expectCommit(input logic [4:0] rd, input logic [2:0] tag,
                              input logic [63:0] value, input logic regWrite);
    commit_t exp;
    exp.valid = 1'b1;
    exp.regWrite = regWrite;
    exp.rd = rd;
    exp.tag = tag;
    exp.value = value;
    expCommits.push_back(exp);
  endtask

  task automatic waitRetired(input int total);
    int waited;
    waited = 0;
    while (retiredCount < total && waited < 40) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (retiredCount < total) begin
      reportFailure($sformatf("only %0d of %0d retirements seen", retiredCount, total));
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic checkCommit();
    commit_t exp;
    if (expCommits.size() == 0) begin
      reportFailure($sformatf("unexpected retirement of tag %0d", commit.tag));
    end else begin
      exp = expCommits.pop_front();
      checkHex("commit_o.tag", 64'(commit.tag), 64'(exp.tag));
      checkHex("commit_o.rd", 64'(commit.rd), 64'(exp.rd));
      checkHex("commit_o.regWrite", 64'(commit.regWrite), 64'(exp.regWrite));
      checkHex("commit_o.value", commit.value, exp.value);
      if (exp.regWrite && exp.rd != 5'd31) begin
        regImage[exp.rd] = exp.value;
      end
      retiredCount++;
    end
  endtask

  // commit_o only moves at the edge, so look late in the cycle
  always begin
    @(posedge clk);
    #3;
    if (rstN && commit.valid) begin
      checkCommit();
    end
  end

  initial begin
    int cycles;
    errors = 0;
    seed = 74925;
    retiredCount = 0;
    expTail = 3'd1;
    for (int i = 0; i < 32; i++) begin
      regImage[i] = '0;
    end
    rstN = 1'b0;
    instValid = 1'b0;
    inst = '0;
    rsStall = '0;
    cdb = '0;
    repeat (8) @(posedge clk);
    #1;
    rstN = 1'b1;
    cycles = 0;
    while (testsDone !== 1'b1 && cycles < 2000) begin
      @(posedge clk);
      cycles++;
    end
    if (testsDone !== 1'b1) begin
      reportFailure("timeout: directed tests did not finish within 2000 cycles");
    end
    if (expCommits.size() != 0) begin
      reportFailure($sformatf("%0d expected retirements never happened", expCommits.size()));
    end
    $display("%0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
hw/renamePkg.sv
hw/regFile.sv
hw/mapTable.sv
hw/reorderBuffer.sv
hw/decodeStage.sv
hw/renameTop.sv
dv/renameTests.sv
dv/renameTb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module renameTb -o renameSim

output=$(./obj_dir/renameSim)
echo "$output"

# the simulation reports failure by leaving out the pass line
echo "$output" | grep -qx "TEST PASSED"
